// File: design/jsp_params.svh
`ifndef JSP_PARAMS_SVH
`define JSP_PARAMS_SVH

// Data path widths
`define JSP_DATA_W      8   // Debug side byte
`define JSP_WORD_W      32  // Wishbone data word
`define JSP_SEL_W       4   // Byte lanes per word

// FIFO sizing
`define JSP_FIFO_DEPTH  8
`define JSP_CNT_W       4   // Holds 0 up to the full depth

// Address map, two words
`define JSP_ADR_HI_BIT  2   // High word holds MCR, LSR, MSR, SCR

// Byte lanes of the low word
`define JSP_LANE_LCR    0
`define JSP_LANE_IIR    1   // IIR on read, FCR on write
`define JSP_LANE_IER    2
`define JSP_LANE_DATA   3   // RBR/THR

// Register constants
`define JSP_LCR_LOW     7'h03   // 8 data bits, no parity, 1 stop
`define JSP_MSR_VAL     8'hB0   // CD, DSR, CTS true, no deltas
`define JSP_FCR_RX_RST  9       // Clears the to-host FIFO
`define JSP_FCR_TX_RST  10      // Clears the from-host FIFO
`define JSP_IIR_RX      3'b100  // Received data available
`define JSP_IIR_THRE    3'b010  // Transmit holding register empty
`define JSP_IIR_NONE    3'b001  // No interrupt pending

`endif

// File: design/jsp_pkg.sv
`include "jsp_params.svh"

package jsp_pkg;

  // Wishbone request as seen inside the port
  typedef struct packed {
    logic                   cyc;
    logic                   stb;
    logic                   we;
    logic                   hi_word;  // Selects the MCR/LSR/MSR/SCR word
    logic [`JSP_SEL_W-1:0]  sel;
    logic [`JSP_WORD_W-1:0] dat;
  } wb_req_t;

  typedef logic [`JSP_CNT_W-1:0] fifo_cnt_t;

  // One FIFO operation per cycle
  typedef struct packed {
    logic en;
    logic push;  // 1 push, 0 pop
  } fifo_cmd_t;

  typedef struct packed {
    fifo_cnt_t avail;  // Bytes stored
    fifo_cnt_t free;   // Slots left
  } fifo_stat_t;

  // Data register accesses that go to the transfer FSMs
  typedef struct packed {
    logic wb_rd;
    logic wb_wr;
  } xfer_req_t;

  typedef enum logic [1:0] {TH_IDLE, TH_PUSH, TH_POP} tohost_state_e;

  typedef enum logic [1:0] {FH_IDLE, FH_PUSH, FH_POP, FH_LATCH} fromhost_state_e;

endpackage

// File: design/jsp_byte_fifo.sv
`timescale 1ns/1ps
`include "jsp_params.svh"

module jsp_byte_fifo (
  input  logic                   wb_clk_i,
  input  logic                   rst_i,
  input  logic                   clr_i,   // Software FIFO reset from FCR
  input  jsp_pkg::fifo_cmd_t     cmd_i,
  input  logic [`JSP_DATA_W-1:0] data_i,
  output logic [`JSP_DATA_W-1:0] data_o,  // Head byte, valid while not empty
  output jsp_pkg::fifo_stat_t    stat_o
);
  import jsp_pkg::*;

  localparam int PTR_W = $clog2(`JSP_FIFO_DEPTH);

  logic [`JSP_DATA_W-1:0] mem [`JSP_FIFO_DEPTH];
  logic [PTR_W-1:0]       wr_ptr;
  logic [PTR_W-1:0]       rd_ptr;
  fifo_cnt_t              count;    // Occupancy
  logic                   arst;     // Power-on or software clear
  logic                   do_push;
  logic                   do_pop;

  assign arst = rst_i | clr_i;

  // Full and empty guards, the command is dropped otherwise
  assign do_push = cmd_i.en & cmd_i.push & (count != fifo_cnt_t'(`JSP_FIFO_DEPTH));
  assign do_pop  = cmd_i.en & ~cmd_i.push & (count != '0);

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge wb_clk_i) begin
    if (do_push) begin
      mem[wr_ptr] <= data_i;
    end
  end

  assign data_o = mem[rd_ptr];  // Stale byte when empty

  ////////////////////////////////////////////////////////////
  // Pointers and count
  ////////////////////////////////////////////////////////////

  always_ff @(posedge wb_clk_i or posedge arst) begin
    if (arst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + PTR_W'(1);  // Wraps at the depth
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + PTR_W'(1);
      end
      if (do_push) begin
        count <= count + fifo_cnt_t'(1);
      end else if (do_pop) begin
        count <= count - fifo_cnt_t'(1);
      end
    end
  end

  assign stat_o.avail = count;
  assign stat_o.free  = fifo_cnt_t'(`JSP_FIFO_DEPTH) - count;

  // Occupancy never runs past the buffer
  a_count_max: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    count <= fifo_cnt_t'(`JSP_FIFO_DEPTH));

  // No transfer FSM drives a FIFO while software clears it
  a_no_cmd_on_clr: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    !(cmd_i.en && clr_i));

endmodule

// File: design/jsp_xfer_ctrl.sv
`timescale 1ns/1ps
`include "jsp_params.svh"

module jsp_xfer_ctrl (
  input  logic                   wb_clk_i,
  input  logic                   rst_i,
  input  logic                   wr_strobe_i,     // Debug side byte on data_i, held until pushed
  input  logic                   rd_strobe_i,     // Debug side took data_o
  input  logic                   debug_select_i,  // Low drains the from-host FIFO
  input  jsp_pkg::xfer_req_t     req_i,
  input  logic [`JSP_DATA_W-1:0] fromhost_head_i,
  input  jsp_pkg::fifo_cnt_t     fromhost_avail_i,
  output jsp_pkg::fifo_cmd_t     tohost_cmd_o,
  output jsp_pkg::fifo_cmd_t     fromhost_cmd_o,
  output logic                   fifo_ack_o,
  output logic                   pop_last_o,      // From-host FIFO going empty
  output logic [`JSP_DATA_W-1:0] data_o
);
  import jsp_pkg::*;

  tohost_state_e   th_state;
  tohost_state_e   th_next;
  fromhost_state_e fh_state;
  fromhost_state_e fh_next;
  logic            wr_pend;      // Debug byte not yet pushed
  logic            rd_pend;      // Debug read not yet served
  logic            wdata_avail;
  logic            pop_req;
  logic            fh_empty;
  logic            latch_en;     // Load data_o from the FIFO head

  assign wdata_avail = wr_strobe_i | wr_pend;
  assign fh_empty    = (fromhost_avail_i == '0);
  assign pop_req     = (rd_strobe_i | rd_pend | ~debug_select_i) & ~fh_empty;  // Auto-drain

  ////////////////////////////////////////////////////////////
  // Pending flags
  ////////////////////////////////////////////////////////////

  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      wr_pend <= 1'b0;
      rd_pend <= 1'b0;
    end else begin
      if (wr_strobe_i) begin
        wr_pend <= 1'b1;
      end else if (th_state == TH_PUSH) begin
        wr_pend <= 1'b0;  // Served
      end
      if (rd_strobe_i) begin
        rd_pend <= 1'b1;
      end else if (fh_state == FH_POP) begin
        rd_pend <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // To-host FSM, bus read wins over the debug push
  ////////////////////////////////////////////////////////////

  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      th_state <= TH_IDLE;
    end else begin
      th_state <= th_next;
    end
  end

  always_comb begin
    th_next = TH_IDLE;
    case (th_state)
      TH_IDLE: begin
        if (req_i.wb_rd)      th_next = TH_POP;
        else if (wdata_avail) th_next = TH_PUSH;
      end
      TH_PUSH: if (req_i.wb_rd) th_next = TH_POP;   // Read waits one cycle at most
      TH_POP:  if (wdata_avail) th_next = TH_PUSH;  // Delayed debug byte goes in now
      default: th_next = TH_IDLE;
    endcase
  end

  assign tohost_cmd_o.en   = (th_state != TH_IDLE);
  assign tohost_cmd_o.push = (th_state == TH_PUSH);

  ////////////////////////////////////////////////////////////
  // From-host FSM and output latch
  ////////////////////////////////////////////////////////////

  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      fh_state <= FH_IDLE;
    end else begin
      fh_state <= fh_next;
    end
  end

  always_comb begin
    fh_next = FH_IDLE;
    case (fh_state)
      FH_IDLE: begin
        if (req_i.wb_wr)  fh_next = FH_PUSH;
        else if (pop_req) fh_next = FH_POP;
      end
      FH_PUSH: begin
        if (fh_empty)     fh_next = FH_LATCH;  // First byte in, show it next cycle
        else if (pop_req) fh_next = FH_POP;
      end
      FH_POP: begin
        // Bus write keeps its one-cycle ack, PUSH picks up the new head
        if (req_i.wb_wr)  fh_next = FH_PUSH;
        else              fh_next = FH_LATCH;
      end
      FH_LATCH: begin
        if (req_i.wb_wr)  fh_next = FH_PUSH;
        else if (pop_req) fh_next = FH_POP;
      end
      default: fh_next = FH_IDLE;
    endcase
  end

  assign fromhost_cmd_o.en   = (fh_state == FH_PUSH) | (fh_state == FH_POP);
  assign fromhost_cmd_o.push = (fh_state == FH_PUSH);

  // Head is settled in LATCH, and in PUSH unless the FIFO was empty
  assign latch_en = (fh_state == FH_LATCH) | ((fh_state == FH_PUSH) & ~fh_empty);

  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      data_o <= '0;
    end else if (latch_en) begin
      data_o <= fromhost_head_i;
    end
  end

  assign fifo_ack_o = (th_state == TH_POP) | (fh_state == FH_PUSH);  // Data register ack
  assign pop_last_o = (fh_state == FH_POP) & (fromhost_avail_i == fifo_cnt_t'(1));

  // Master drops stb after the ack, so a FIFO ack is a single pulse
  a_ack_pulse: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    fifo_ack_o |=> !fifo_ack_o);

endmodule

// File: design/jsp_uart_regs.sv
`timescale 1ns/1ps
`include "jsp_params.svh"

module jsp_uart_regs (
  input  logic                   wb_clk_i,
  input  logic                   rst_i,
  input  jsp_pkg::wb_req_t       req_i,
  input  logic                   fifo_ack_i,       // Data register ack from the FSMs
  input  logic                   pop_last_i,
  input  logic [`JSP_DATA_W-1:0] tohost_head_i,    // RBR value
  input  jsp_pkg::fifo_stat_t    tohost_stat_i,
  input  jsp_pkg::fifo_stat_t    fromhost_stat_i,
  output jsp_pkg::xfer_req_t     xfer_o,
  output logic                   rx_fifo_rst_o,    // Clears the to-host FIFO
  output logic                   tx_fifo_rst_o,    // Clears the from-host FIFO
  output logic [`JSP_WORD_W-1:0] wb_dat_o,
  output logic                   wb_ack_o,
  output logic                   int_o
);
  import jsp_pkg::*;

  logic                   dlab;          // LCR bit 7
  logic [3:0]             ier;
  logic                   thr_arm;       // THRE interrupt armed
  logic                   bus_acc;
  logic                   fifo_acc;
  logic                   reg_ack;
  logic                   reg_wr;        // Acked write to the low word
  logic                   reg_rd;        // Acked read of the low word
  logic                   fcr_wr;
  logic                   th_not_empty;
  logic                   fh_not_full;
  logic [2:0]             iir;
  logic [7:0]             lcr;
  logic [7:0]             lsr;
  logic [`JSP_WORD_W-1:0] word_lo;
  logic [`JSP_WORD_W-1:0] word_hi;

  ////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////

  assign bus_acc  = req_i.cyc & req_i.stb;
  assign fifo_acc = ~req_i.hi_word & req_i.sel[`JSP_LANE_DATA];  // RBR/THR lane

  // Data register traffic goes to the FSMs unless DLAB hides it
  assign xfer_o.wb_rd = bus_acc & ~req_i.we & fifo_acc & ~dlab;
  assign xfer_o.wb_wr = bus_acc & req_i.we & fifo_acc & ~dlab;

  // Plain registers answer in the same cycle
  assign reg_ack  = bus_acc & (|req_i.sel) & (dlab | ~fifo_acc);
  assign wb_ack_o = reg_ack | fifo_ack_i;

  assign reg_wr = bus_acc & req_i.we & ~req_i.hi_word & wb_ack_o;
  assign reg_rd = bus_acc & ~req_i.we & ~req_i.hi_word & wb_ack_o;
  assign fcr_wr = reg_wr & req_i.sel[`JSP_LANE_IIR];

  assign rx_fifo_rst_o = fcr_wr & req_i.dat[`JSP_FCR_RX_RST];
  assign tx_fifo_rst_o = fcr_wr & req_i.dat[`JSP_FCR_TX_RST];

  ////////////////////////////////////////////////////////////
  // Writable state
  ////////////////////////////////////////////////////////////

  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      dlab    <= 1'b0;
      ier     <= '0;
      thr_arm <= 1'b0;
    end else begin
      if (reg_wr & req_i.sel[`JSP_LANE_LCR]) begin
        dlab <= req_i.dat[`JSP_LANE_LCR*8 + 7];
      end
      if (reg_wr & req_i.sel[`JSP_LANE_IER] & ~dlab) begin
        ier <= req_i.dat[`JSP_LANE_IER*8 +: 4];  // Only the low nibble exists
      end
      if (xfer_o.wb_wr | pop_last_i) begin
        thr_arm <= 1'b1;  // Bus wrote, or from-host FIFO drained
      end else if (reg_rd & req_i.sel[`JSP_LANE_IIR] & ~th_not_empty) begin
        thr_arm <= 1'b0;  // IIR read acknowledges THRE
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Read side
  ////////////////////////////////////////////////////////////

  assign th_not_empty = (tohost_stat_i.avail != '0);
  assign fh_not_full  = (fromhost_stat_i.free != '0);

  // Priority: received data, then THRE
  always_comb begin
    if (th_not_empty) begin
      iir = `JSP_IIR_RX;
    end else if (thr_arm & fh_not_full) begin
      iir = `JSP_IIR_THRE;
    end else begin
      iir = `JSP_IIR_NONE;
    end
  end

  assign lcr = {dlab, `JSP_LCR_LOW};
  assign lsr = {1'b0, fh_not_full, fh_not_full, 4'b0000, th_not_empty};  // TEMT, THRE, DR

  assign word_lo = {tohost_head_i, {4'b0000, ier}, {5'b00000, iir}, lcr};
  assign word_hi = {8'h00, lsr, `JSP_MSR_VAL, 8'h00};  // MCR and SCR read zero

  assign wb_dat_o = req_i.hi_word ? word_hi : word_lo;

  assign int_o = (th_not_empty & ier[0]) | (fh_not_full & thr_arm & ier[1]);

endmodule

// File: design/jtag_serial_port.sv
`timescale 1ns/1ps
`include "jsp_params.svh"

module jtag_serial_port (
  input  logic                   wb_clk_i,
  input  logic                   rst_i,
  // Debug side
  input  logic [`JSP_DATA_W-1:0] data_i,
  output logic [`JSP_DATA_W-1:0] data_o,
  output jsp_pkg::fifo_cnt_t     bytes_free_o,       // Room in the to-host FIFO
  output jsp_pkg::fifo_cnt_t     bytes_available_o,  // Bytes waiting from the host
  input  logic                   rd_strobe_i,
  input  logic                   wr_strobe_i,
  input  logic                   debug_select_i,
  // Wishbone slave
  input  logic [31:0]            wb_adr_i,
  input  logic [`JSP_WORD_W-1:0] wb_dat_i,
  output logic [`JSP_WORD_W-1:0] wb_dat_o,
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  input  logic [`JSP_SEL_W-1:0]  wb_sel_i,
  input  logic                   wb_we_i,
  output logic                   wb_ack_o,
  output logic                   int_o
);
  import jsp_pkg::*;

  wb_req_t                bus_req;
  xfer_req_t              xfer_req;
  fifo_cmd_t              tohost_cmd;
  fifo_cmd_t              fromhost_cmd;
  fifo_stat_t             tohost_stat;
  fifo_stat_t             fromhost_stat;
  logic [`JSP_DATA_W-1:0] tohost_head;
  logic [`JSP_DATA_W-1:0] fromhost_head;
  logic                   rx_fifo_rst;
  logic                   tx_fifo_rst;
  logic                   fifo_ack;
  logic                   pop_last;

  assign bus_req = '{cyc: wb_cyc_i, stb: wb_stb_i, we: wb_we_i,
                     hi_word: wb_adr_i[`JSP_ADR_HI_BIT], sel: wb_sel_i, dat: wb_dat_i};

  // Debug side writes, bus reads
  jsp_byte_fifo u_tohost_fifo (
    .wb_clk_i (wb_clk_i),
    .rst_i    (rst_i),
    .clr_i    (rx_fifo_rst),
    .cmd_i    (tohost_cmd),
    .data_i   (data_i),
    .data_o   (tohost_head),
    .stat_o   (tohost_stat)
  );

  // Bus writes the THR lane, debug side reads
  jsp_byte_fifo u_fromhost_fifo (
    .wb_clk_i (wb_clk_i),
    .rst_i    (rst_i),
    .clr_i    (tx_fifo_rst),
    .cmd_i    (fromhost_cmd),
    .data_i   (wb_dat_i[`JSP_LANE_DATA*8 +: `JSP_DATA_W]),
    .data_o   (fromhost_head),
    .stat_o   (fromhost_stat)
  );

  jsp_xfer_ctrl u_xfer_ctrl (
    .wb_clk_i         (wb_clk_i),
    .rst_i            (rst_i),
    .wr_strobe_i      (wr_strobe_i),
    .rd_strobe_i      (rd_strobe_i),
    .debug_select_i   (debug_select_i),
    .req_i            (xfer_req),
    .fromhost_head_i  (fromhost_head),
    .fromhost_avail_i (fromhost_stat.avail),
    .tohost_cmd_o     (tohost_cmd),
    .fromhost_cmd_o   (fromhost_cmd),
    .fifo_ack_o       (fifo_ack),
    .pop_last_o       (pop_last),
    .data_o           (data_o)
  );

  jsp_uart_regs u_uart_regs (
    .wb_clk_i        (wb_clk_i),
    .rst_i           (rst_i),
    .req_i           (bus_req),
    .fifo_ack_i      (fifo_ack),
    .pop_last_i      (pop_last),
    .tohost_head_i   (tohost_head),
    .tohost_stat_i   (tohost_stat),
    .fromhost_stat_i (fromhost_stat),
    .xfer_o          (xfer_req),
    .rx_fifo_rst_o   (rx_fifo_rst),
    .tx_fifo_rst_o   (tx_fifo_rst),
    .wb_dat_o        (wb_dat_o),
    .wb_ack_o        (wb_ack_o),
    .int_o           (int_o)
  );

  assign bytes_free_o      = tohost_stat.free;
  assign bytes_available_o = fromhost_stat.avail;

endmodule

// File: testbench/tb_jtag_serial_port.sv
`timescale 1ns/1ps
`include "jsp_params.svh"

module tb_jtag_serial_port;
  import jsp_pkg::*;

  localparam int TIMEOUT = 200;  // Cycles per wait loop

  typedef enum logic [2:0] {
    OP_BUS_RD, OP_BUS_WR, OP_DBG_WR, OP_DBG_RD, OP_COUNT, OP_INT, OP_SEL, OP_DATA
  } op_e;

  // One table row; exp is a count for debug ops, wdat the byte
  typedef struct packed {
    op_e         op;
    logic        hi;     // High word, or the avail count for OP_COUNT
    logic [3:0]  sel;
    logic [31:0] wdat;
    logic [31:0] exp;
    logic [31:0] mask;
    logic        lat;    // Ack one cycle after stb
  } step_t;

  step_t       steps[$];
  string       names[$];
  logic [31:0] lfsr;
  logic [7:0]  b[8];
  logic [7:0]  x;

  logic                   wb_clk_i;
  logic                   rst_i;
  logic [`JSP_DATA_W-1:0] data_i;
  logic [`JSP_DATA_W-1:0] data_o;
  fifo_cnt_t              bytes_free_o;
  fifo_cnt_t              bytes_available_o;
  logic                   rd_strobe_i;
  logic                   wr_strobe_i;
  logic                   debug_select_i;
  logic [31:0]            wb_adr_i;
  logic [31:0]            wb_dat_i;
  logic [31:0]            wb_dat_o;
  logic                   wb_cyc_i;
  logic                   wb_stb_i;
  logic [3:0]             wb_sel_i;
  logic                   wb_we_i;
  logic                   wb_ack_o;
  logic                   int_o;

  jtag_serial_port jtag_serial_port_i (
    .wb_clk_i (wb_clk_i), .rst_i (rst_i), .data_i (data_i), .data_o (data_o),
    .bytes_free_o (bytes_free_o), .bytes_available_o (bytes_available_o),
    .rd_strobe_i (rd_strobe_i), .wr_strobe_i (wr_strobe_i),
    .debug_select_i (debug_select_i), .wb_adr_i (wb_adr_i), .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o), .wb_cyc_i (wb_cyc_i), .wb_stb_i (wb_stb_i),
    .wb_sel_i (wb_sel_i), .wb_we_i (wb_we_i), .wb_ack_o (wb_ack_o), .int_o (int_o)
  );

  initial begin
    wb_clk_i = 1'b0;
    forever #5 wb_clk_i = ~wb_clk_i;  // 100 MHz
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("STATUS: FAIL");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) abort_run($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) abort_run($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_count(input string name, input fifo_cnt_t exp, input fifo_cnt_t act);
    if (act !== exp) abort_run($sformatf("[FAIL] %s expected %0d actual %0d", name, exp, act));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) abort_run($sformatf("[FAIL] %s expected %b actual %b", name, exp, act));
  endtask

  // Galois form, taps 32,22,2,1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic rand_byte(output logic [7:0] v);
    v = '0;
    repeat (8) begin
      lfsr = lfsr_step(lfsr);  // One step per bit
      v = {v[6:0], lfsr[0]};
    end
  endtask

  task automatic add_step(input op_e op, input logic hi, input logic [3:0] sel,
                          input logic [31:0] wdat, input logic [31:0] exp,
                          input logic [31:0] mask, input logic lat, input string name);
    step_t s;
    s = '{op: op, hi: hi, sel: sel, wdat: wdat, exp: exp, mask: mask, lat: lat};
    steps.push_back(s);
    names.push_back(name);
  endtask

  // Classic cycle, stb held until the ack is seen
  task automatic bus_access(input logic we, input logic hi, input logic [3:0] sel,
                            input logic [31:0] wdat, output logic [31:0] rdat,
                            output int lat);
    int n;
    n = 0;
    @(posedge wb_clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_adr_i <= hi ? 32'h4 : 32'h0;
    wb_sel_i <= sel;
    wb_dat_i <= wdat;
    @(negedge wb_clk_i);
    while (!wb_ack_o) begin
      n++;
      if (n > TIMEOUT) abort_run("Timeout: the Wishbone access was never acknowledged");
      @(negedge wb_clk_i);
    end
    rdat = wb_dat_o;
    lat  = n;
    @(posedge wb_clk_i);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
    wb_sel_i <= '0;
  endtask

  task automatic wait_count(input logic avail, input fifo_cnt_t exp, input string name);
    int        n;
    fifo_cnt_t act;
    n = 0;
    @(negedge wb_clk_i);
    act = avail ? bytes_available_o : bytes_free_o;
    while (act !== exp && n < TIMEOUT) begin
      @(negedge wb_clk_i);
      n++;
      act = avail ? bytes_available_o : bytes_free_o;
    end
    if (act !== exp) begin
      $display("Timeout: a FIFO count never settled in %s", name);
    end
    check_count(name, exp, act);
  endtask

  task automatic run_step(input step_t s, input string name);
    logic [31:0] rdat;
    int          lat;
    case (s.op)
      OP_BUS_RD, OP_BUS_WR: begin
        bus_access(s.op == OP_BUS_WR, s.hi, s.sel, s.wdat, rdat, lat);
        if (s.op == OP_BUS_RD && s.mask != '0) check_word(name, s.exp, rdat & s.mask);
        check_word({name, " ack cycle"}, {31'b0, s.lat}, lat[31:0]);
      end
      OP_DBG_WR: begin
        @(posedge wb_clk_i);
        data_i      <= s.wdat[7:0];  // Held until the next debug write
        wr_strobe_i <= 1'b1;
        @(posedge wb_clk_i);
        wr_strobe_i <= 1'b0;
        wait_count(1'b0, s.exp[`JSP_CNT_W-1:0], name);
      end
      OP_DBG_RD: begin
        @(posedge wb_clk_i);
        rd_strobe_i <= 1'b1;
        @(posedge wb_clk_i);
        rd_strobe_i <= 1'b0;
        wait_count(1'b1, s.exp[`JSP_CNT_W-1:0], name);
        @(posedge wb_clk_i);  // LATCH loads the new head
        @(negedge wb_clk_i);
        check_byte(name, s.wdat[7:0], data_o);
      end
      OP_COUNT: wait_count(s.hi, s.exp[`JSP_CNT_W-1:0], name);
      OP_INT: begin
        @(negedge wb_clk_i);
        check_bit(name, s.exp[0], int_o);
      end
      OP_SEL: begin
        @(posedge wb_clk_i);
        debug_select_i <= s.wdat[0];
      end
      default: begin
        @(negedge wb_clk_i);
        check_byte(name, s.exp[7:0], data_o);
      end
    endcase
  endtask

  ////////////////////////////////////////////////////////////
  // Table and run
  ////////////////////////////////////////////////////////////

  initial begin
    rst_i = 1'b1;
    data_i = '0;
    rd_strobe_i = 1'b0;
    wr_strobe_i = 1'b0;
    debug_select_i = 1'b1;
    wb_adr_i = '0;
    wb_dat_i = '0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_sel_i = '0;
    wb_we_i = 1'b0;
    lfsr = 32'h829ecec9;

    // Reset values
    add_step(OP_BUS_RD, 0, 4'b0111, 0, 32'h00000103, 32'h00FFFFFF, 0, "reset low word");
    add_step(OP_BUS_RD, 1, 4'b1111, 0, 32'h0060B000, 32'hFFFFFFFF, 0, "reset high word");
    add_step(OP_COUNT, 0, 0, 0, 8, 0, 0, "reset bytes_free");
    add_step(OP_COUNT, 1, 0, 0, 0, 0, 0, "reset bytes_available");
    add_step(OP_INT, 0, 0, 0, 0, 0, 0, "reset int");
    add_step(OP_DATA, 0, 0, 0, 0, 0, 0, "reset data_o");
    // Debug side to host, FIFO order
    for (int i = 0; i < 8; i++) begin
      rand_byte(b[i]);
      add_step(OP_DBG_WR, 0, 0, {24'b0, b[i]}, 7 - i, 0, 0, $sformatf("debug write %0d", i));
    end
    add_step(OP_BUS_RD, 1, 4'b0100, 0, 32'h00010000, 32'h00010000, 0, "LSR data ready");
    for (int i = 0; i < 8; i++) begin
      add_step(OP_BUS_RD, 0, 4'b1000, 0, {b[i], 24'b0}, 32'hFF000000, 1,
               $sformatf("host read %0d", i));
    end
    add_step(OP_BUS_RD, 1, 4'b0100, 0, 32'h0, 32'h00010000, 0, "LSR drained");
    // Host to debug side, then auto-drain
    for (int i = 0; i < 4; i++) begin
      rand_byte(b[i]);
      add_step(OP_BUS_WR, 0, 4'b1000, {b[i], 24'b0}, 0, 0, 1, $sformatf("host write %0d", i));
    end
    add_step(OP_COUNT, 1, 0, 0, 4, 0, 0, "avail after writes");
    add_step(OP_DATA, 0, 0, 0, {24'b0, b[0]}, 0, 0, "first byte on data_o");
    for (int i = 1; i < 4; i++) begin
      add_step(OP_DBG_RD, 0, 0, {24'b0, b[i]}, 4 - i, 0, 0, $sformatf("debug read %0d", i));
    end
    add_step(OP_SEL, 0, 0, 0, 0, 0, 0, "deselect");
    add_step(OP_COUNT, 1, 0, 0, 0, 0, 0, "auto drain");
    // DLAB hides the data register
    add_step(OP_SEL, 0, 0, 1, 0, 0, 0, "select");
    rand_byte(x);
    add_step(OP_DBG_WR, 0, 0, {24'b0, x}, 7, 0, 0, "debug write before DLAB");
    add_step(OP_BUS_WR, 0, 4'b0001, 32'h83, 0, 0, 0, "set DLAB");
    add_step(OP_BUS_RD, 0, 4'b0001, 0, 32'h83, 32'hFF, 0, "LCR with DLAB");
    add_step(OP_BUS_RD, 0, 4'b1000, 0, 0, 0, 0, "DLAB data read");
    add_step(OP_BUS_WR, 0, 4'b1000, 32'h5A000000, 0, 0, 0, "DLAB data write");
    add_step(OP_COUNT, 0, 0, 0, 7, 0, 0, "free kept under DLAB");
    add_step(OP_COUNT, 1, 0, 0, 0, 0, 0, "avail kept under DLAB");
    add_step(OP_BUS_WR, 0, 4'b0001, 32'h03, 0, 0, 0, "clear DLAB");
    add_step(OP_BUS_RD, 0, 4'b1000, 0, {x, 24'b0}, 32'hFF000000, 1, "read after DLAB");
    add_step(OP_COUNT, 0, 0, 0, 8, 0, 0, "free after DLAB");
    // Interrupts, received data then THRE
    rand_byte(x);
    add_step(OP_BUS_WR, 0, 4'b0100, 32'h00010000, 0, 0, 0, "IER rx");
    add_step(OP_DBG_WR, 0, 0, {24'b0, x}, 7, 0, 0, "debug write for rx int");
    add_step(OP_INT, 0, 0, 0, 1, 0, 0, "rx int high");
    add_step(OP_BUS_RD, 0, 4'b0010, 0, 32'h400, 32'h700, 0, "IIR rx");
    add_step(OP_BUS_RD, 0, 4'b1000, 0, {x, 24'b0}, 32'hFF000000, 1, "rx int byte");
    add_step(OP_INT, 0, 0, 0, 0, 0, 0, "rx int low");
    add_step(OP_BUS_WR, 0, 4'b0100, 32'h00020000, 0, 0, 0, "IER thre");
    add_step(OP_BUS_RD, 0, 4'b0010, 0, 32'h200, 32'h700, 0, "IIR thre armed");
    add_step(OP_INT, 0, 0, 0, 0, 0, 0, "thre int disarmed");
    add_step(OP_SEL, 0, 0, 0, 0, 0, 0, "deselect for thre");
    add_step(OP_BUS_WR, 0, 4'b1000, 32'hC3000000, 0, 0, 1, "host write for thre");
    add_step(OP_COUNT, 1, 0, 0, 0, 0, 0, "thre drain");
    add_step(OP_INT, 0, 0, 0, 1, 0, 0, "thre int high");
    add_step(OP_BUS_RD, 0, 4'b0010, 0, 32'h200, 32'h700, 0, "IIR thre");
    add_step(OP_INT, 0, 0, 0, 0, 0, 0, "thre int cleared");
    add_step(OP_SEL, 0, 0, 1, 0, 0, 0, "select for FCR");
    // FCR resets
    add_step(OP_DBG_WR, 0, 0, 32'h11, 7, 0, 0, "FCR fill tohost 0");
    add_step(OP_DBG_WR, 0, 0, 32'h22, 6, 0, 0, "FCR fill tohost 1");
    add_step(OP_BUS_WR, 0, 4'b1000, 32'h33000000, 0, 0, 1, "FCR fill fromhost 0");
    add_step(OP_BUS_WR, 0, 4'b1000, 32'h44000000, 0, 0, 1, "FCR fill fromhost 1");
    add_step(OP_COUNT, 1, 0, 0, 2, 0, 0, "avail before FCR");
    add_step(OP_BUS_WR, 0, 4'b0010, 32'h200, 0, 0, 0, "FCR rx reset");
    add_step(OP_COUNT, 0, 0, 0, 8, 0, 0, "free after FCR");
    add_step(OP_BUS_WR, 0, 4'b0010, 32'h400, 0, 0, 0, "FCR tx reset");
    add_step(OP_COUNT, 1, 0, 0, 0, 0, 0, "avail after FCR");

    repeat (16) @(posedge wb_clk_i);
    rst_i <= 1'b0;
    foreach (steps[i]) run_step(steps[i], names[i]);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// File: jtag_serial_port.f
+incdir+design
design/jsp_pkg.sv
design/jsp_byte_fifo.sv
design/jsp_xfer_ctrl.sv
design/jsp_uart_regs.sv
design/jtag_serial_port.sv
testbench/tb_jtag_serial_port.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator, pass only on the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f jtag_serial_port.f \
  --top-module tb_jtag_serial_port -o tb_sim \
  && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "STATUS: PASS" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
